// File: all.f
rtl/dagPkg.sv
rtl/lookaheadAdder.sv
rtl/moduloUpdate.sv
rtl/dagRegisterFile.sv
rtl/accessSequencer.sv
rtl/addressGenerator.sv
sim/clockGen.sv
sim/addressGenerator_asserts.sv
sim/addressGeneratorTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module addressGeneratorTb \
  -f all.f \
  -o addressGeneratorSim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/addressGeneratorSim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// File: sim/addressGeneratorTb.sv
`timescale 1ns/100ps

module addressGeneratorTb;

  localparam int ackTimeout = 20;
  localparam int randomSteps = 300;

  // one request with the response it should produce.
  typedef struct packed
  {
    dagPkg::dagOpT   op;
    dagPkg::regKindT kind;
    dagPkg::regSelT  indexSel;
    dagPkg::regSelT  modifySel;
    dagPkg::addrT    data;
    dagPkg::addrT    expAddress;
    logic            expWrap;
    logic [2:0]      hold;
  } stepT;

  logic                clk;
  logic                reset;
  logic                req;
  dagPkg::dagRequestT  request;
  logic                ack;
  dagPkg::dagResponseT response;

  stepT         steps [$];
  dagPkg::addrT shadowIndex [dagPkg::numRegs];
  dagPkg::addrT shadowModify [dagPkg::numRegs];
  dagPkg::addrT shadowLength [dagPkg::numRegs];
  int           seed;

  clockGen u_clock
  (
    .clk   (clk),
    .reset (reset)
  );

  addressGenerator i_dut
  (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .request  (request),
    .ack      (ack),
    .response (response)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // circular-buffer post-modify, written straight from the offset field rule.
  function automatic void predictUpdate(input dagPkg::addrT index, input dagPkg::addrT modifier,
                                        input dagPkg::addrT length,
                                        output dagPkg::addrT nextIndex, output logic wrapped);
    int           lenValue;
    int           stride;
    int           offsetValue;
    int           sumValue;
    int           resultValue;
    int           top;
    dagPkg::addrT mask;
    lenValue = length;
    stride = $signed(modifier);
    top = 0;
    if (length == '0)
    begin
      mask = '1;
    end
    else if ((length & (length - 14'd1)) == '0)
    begin
      mask = length - 14'd1;
    end
    else
    begin
      for (int i = 0; i < dagPkg::addrWidth; i++)
      begin
        if (length[i])
        begin
          top = i;
        end
      end
      mask = dagPkg::addrT'((1 << (top + 1)) - 1);
    end
    offsetValue = int'(index & mask);
    sumValue = offsetValue + stride;
    if (stride >= 0 && lenValue != 0 && sumValue >= lenValue)
    begin
      resultValue = sumValue - lenValue;
      wrapped = 1'b1;
    end
    else if (stride < 0 && lenValue != 0 && sumValue < 0)
    begin
      resultValue = sumValue + lenValue;
      wrapped = 1'b1;
    end
    else
    begin
      resultValue = sumValue & int'(mask);
      wrapped = 1'b0;
    end
    nextIndex = (index & ~mask) | dagPkg::addrT'(resultValue);
  endfunction

  task automatic failRun(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkAddress(input dagPkg::addrT actual, input dagPkg::addrT expected,
                              input string what);
    if (actual !== expected)
    begin
      failRun($sformatf("error at %0.1f ns: %s returned address 0x%04h, expected 0x%04h",
                        $realtime, what, actual, expected));
    end
  endtask

  task automatic checkWrap(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      failRun($sformatf("error at %0.1f ns: %s returned wrap %0b, expected %0b",
                        $realtime, what, actual, expected));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request channel.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // polls ack just after each rising edge, where the DUT outputs have settled.
  task automatic waitForAck(input logic level, input string what, output int cycles);
    cycles = 0;
    while (ack !== level)
    begin
      @(posedge clk);
      #0.5;
      cycles++;
      if (cycles > ackTimeout)
      begin
        failRun($sformatf("timeout: ack did not become %0b within %0d cycles %s",
                          level, ackTimeout, what));
      end
    end
  endtask

  task automatic runHandshake(input stepT step, input string what,
                              output dagPkg::dagResponseT resp);
    dagPkg::dagRequestT rq;
    int                 cycles;
    rq.op = step.op;
    rq.kind = step.kind;
    rq.indexSel = step.indexSel;
    rq.modifySel = step.modifySel;
    rq.data = step.data;
    waitForAck(1'b0, "before a new request", cycles);
    request = rq;
    req = 1'b1;
    waitForAck(1'b1, "after req was raised", cycles);
    // req is first sampled one edge later, and ack follows two edges after that.
    if (cycles != 3)
    begin
      failRun($sformatf("error at %0.1f ns: %s saw ack after %0d edges, expected 3",
                        $realtime, what, cycles));
    end
    resp = response;
    repeat (step.hold)
    begin
      @(posedge clk);
      #0.5;
      if (ack !== 1'b1)
      begin
        failRun($sformatf("%s: ack dropped while req was still held high", what));
      end
      checkAddress(response.address, step.expAddress, {what, " under back-pressure"});
      checkWrap(response.wrap, step.expWrap, {what, " under back-pressure"});
    end
    req = 1'b0;
    waitForAck(1'b0, "after req was released", cycles);
  endtask

  // runs one step, checks it and keeps the shadow registers in line.
  task automatic applyStep(input stepT step, input string what);
    dagPkg::dagResponseT resp;
    dagPkg::addrT        nextIndex;
    logic                wrapped;
    runHandshake(step, what, resp);
    checkAddress(resp.address, step.expAddress, what);
    checkWrap(resp.wrap, step.expWrap, what);
    if (step.op == dagPkg::opAccess)
    begin
      predictUpdate(shadowIndex[step.indexSel], shadowModify[step.modifySel],
                    shadowLength[step.indexSel], nextIndex, wrapped);
      shadowIndex[step.indexSel] = nextIndex;
    end
    else
    begin
      case (step.kind)
        dagPkg::kindIndex:
        begin
          shadowIndex[step.indexSel] = step.data;
        end
        dagPkg::kindModify:
        begin
          shadowModify[step.modifySel] = step.data;
        end
        dagPkg::kindLength:
        begin
          shadowLength[step.indexSel] = step.data;
        end
        default:
        begin
        end
      endcase
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic addWrite(input dagPkg::regKindT kind, input dagPkg::regSelT sel,
                          input dagPkg::addrT data);
    stepT step;
    step = '0;
    step.op = dagPkg::opWrite;
    step.kind = kind;
    step.indexSel = sel;
    step.modifySel = sel;
    step.data = data;
    step.expAddress = data;
    steps.push_back(step);
  endtask

  task automatic addAccess(input dagPkg::regSelT indexSel, input dagPkg::regSelT modifySel,
                           input dagPkg::addrT expAddress, input logic expWrap,
                           input logic [2:0] hold);
    stepT step;
    step = '0;
    step.op = dagPkg::opAccess;
    step.kind = dagPkg::kindIndex;
    step.indexSel = indexSel;
    step.modifySel = modifySel;
    step.expAddress = expAddress;
    step.expWrap = expWrap;
    step.hold = hold;
    steps.push_back(step);
  endtask

  task automatic buildTable();
    // all registers start at zero, so I0 stays put.
    addAccess(2'd0, 2'd0, 14'h0000, 1'b0, 3'd0);
    addAccess(2'd0, 2'd0, 14'h0000, 1'b0, 3'd0);
    // linear mode rolls over modulo 2^14 and never wraps.
    addWrite(dagPkg::kindIndex, 2'd1, 14'h3FF0);
    addWrite(dagPkg::kindModify, 2'd1, 14'h0007);
    addAccess(2'd1, 2'd1, 14'h3FF0, 1'b0, 3'd0);
    addAccess(2'd1, 2'd1, 14'h3FF7, 1'b0, 3'd0);
    addAccess(2'd1, 2'd1, 14'h3FFE, 1'b0, 3'd0);
    addAccess(2'd1, 2'd1, 14'h0005, 1'b0, 3'd0);
    addWrite(dagPkg::kindModify, 2'd1, 14'h3FFD);
    addAccess(2'd1, 2'd1, 14'h000C, 1'b0, 3'd0);
    addAccess(2'd1, 2'd1, 14'h0009, 1'b0, 3'd0);
    // L = 10 with M = 3 walks the offsets 0, 3, 6, 9, 2, 5, 8, 1.
    addWrite(dagPkg::kindIndex, 2'd2, 14'h0100);
    addWrite(dagPkg::kindLength, 2'd2, 14'h000A);
    addWrite(dagPkg::kindModify, 2'd2, 14'h0003);
    addAccess(2'd2, 2'd2, 14'h0100, 1'b0, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0103, 1'b0, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0106, 1'b0, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0109, 1'b1, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0102, 1'b0, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0105, 1'b0, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0108, 1'b1, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0101, 1'b0, 3'd0);
    // M = -4 with L = 10, base 0x2A50 must survive every step.
    addWrite(dagPkg::kindIndex, 2'd3, 14'h2A52);
    addWrite(dagPkg::kindLength, 2'd3, 14'h000A);
    addWrite(dagPkg::kindModify, 2'd3, 14'h3FFC);
    addAccess(2'd3, 2'd3, 14'h2A52, 1'b1, 3'd0);
    addAccess(2'd3, 2'd3, 14'h2A58, 1'b0, 3'd0);
    addAccess(2'd3, 2'd3, 14'h2A54, 1'b0, 3'd0);
    addAccess(2'd3, 2'd3, 14'h2A50, 1'b1, 3'd0);
    addAccess(2'd3, 2'd3, 14'h2A56, 1'b0, 3'd0);
    // L = 16 keeps the offset in bits 3..0 under base 0x1230.
    addWrite(dagPkg::kindLength, 2'd0, 14'h0010);
    addWrite(dagPkg::kindIndex, 2'd0, 14'h1237);
    addWrite(dagPkg::kindModify, 2'd0, 14'h0005);
    addAccess(2'd0, 2'd0, 14'h1237, 1'b0, 3'd0);
    addAccess(2'd0, 2'd0, 14'h123C, 1'b1, 3'd0);
    addAccess(2'd0, 2'd0, 14'h1231, 1'b0, 3'd0);
    addAccess(2'd0, 2'd0, 14'h1236, 1'b0, 3'd0);
    addAccess(2'd0, 2'd0, 14'h123B, 1'b1, 3'd0);
    addAccess(2'd0, 2'd0, 14'h1230, 1'b0, 3'd0);
    // a step of -16 is a full turn of the buffer.
    addWrite(dagPkg::kindModify, 2'd0, 14'h3FF0);
    addAccess(2'd0, 2'd0, 14'h1235, 1'b1, 3'd0);
    addAccess(2'd0, 2'd0, 14'h1235, 1'b1, 3'd0);
    // held req must not cause a second update.
    addAccess(2'd2, 2'd2, 14'h0104, 1'b0, 3'd5);
    addAccess(2'd2, 2'd2, 14'h0107, 1'b1, 3'd0);
    addAccess(2'd2, 2'd2, 14'h0100, 1'b0, 3'd0);
    // writes to set 1 leave sets 2 and 3 alone.
    addWrite(dagPkg::kindModify, 2'd1, 14'h0002);
    addWrite(dagPkg::kindLength, 2'd1, 14'h0005);
    addAccess(2'd2, 2'd2, 14'h0103, 1'b0, 3'd0);
    addAccess(2'd3, 2'd3, 14'h2A52, 1'b1, 3'd2);
    addAccess(2'd1, 2'd2, 14'h0006, 1'b1, 3'd0);
    addAccess(2'd1, 2'd1, 14'h0004, 1'b1, 3'd0);
    addAccess(2'd1, 2'd1, 14'h0001, 1'b0, 3'd0);
  endtask

  // lengths stay below 1024 so the offset sum cannot overflow its sign bit.
  task automatic randomPhase(input int count);
    stepT         step;
    dagPkg::addrT nextIndex;
    logic         wrapped;
    int           pick;
    for (int n = 0; n < count; n++)
    begin
      step = '0;
      step.indexSel = dagPkg::regSelT'($random(seed));
      step.modifySel = dagPkg::regSelT'($random(seed));
      step.hold = 3'($unsigned($random(seed)) % 3);
      pick = $unsigned($random(seed)) % 10;
      if (pick < 6)
      begin
        step.op = dagPkg::opAccess;
        step.kind = dagPkg::kindIndex;
        predictUpdate(shadowIndex[step.indexSel], shadowModify[step.modifySel],
                      shadowLength[step.indexSel], nextIndex, wrapped);
        step.expAddress = shadowIndex[step.indexSel];
        step.expWrap = wrapped;
      end
      else
      begin
        step.op = dagPkg::opWrite;
        if (pick == 6)
        begin
          step.kind = dagPkg::kindIndex;
          step.data = dagPkg::addrT'($random(seed));
        end
        else if (pick < 9)
        begin
          step.kind = dagPkg::kindModify;
          step.data = dagPkg::addrT'($random(seed) % 64);
        end
        else
        begin
          step.kind = dagPkg::kindLength;
          pick = $unsigned($random(seed)) % 4;
          if (pick == 0)
          begin
            step.data = '0;
          end
          else if (pick == 1)
          begin
            step.data = dagPkg::addrT'(14'd1 << ($unsigned($random(seed)) % 10));
          end
          else
          begin
            step.data = dagPkg::addrT'($random(seed)) & 14'h03FF;
          end
        end
        step.expAddress = step.data;
      end
      applyStep(step, $sformatf("random step %0d", n));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : mainFlow
    int waited;
    req = 1'b0;
    request = '0;
    seed = 91;
    for (int i = 0; i < dagPkg::numRegs; i++)
    begin
      shadowIndex[i] = '0;
      shadowModify[i] = '0;
      shadowLength[i] = '0;
    end
    buildTable();
    waited = 0;
    @(posedge clk);
    while (reset)
    begin
      @(posedge clk);
      waited++;
      if (waited > 10)
      begin
        failRun("reset was never released");
      end
    end
    #0.5;
    checkAddress(response.address, 14'h0000, "response after reset");
    checkWrap(response.wrap, 1'b0, "response after reset");
    for (int i = 0; i < steps.size(); i++)
    begin
      applyStep(steps[i], $sformatf("table row %0d", i));
    end
    randomPhase(randomSteps);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: sim/addressGenerator_asserts.sv
`timescale 1ns/100ps

module addressGenerator_asserts
(
  input logic                clk,
  input logic                reset,
  input logic                req,
  input logic                ack,
  input dagPkg::dagResponseT response
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase handshake rules.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ackLowAfterReset: assert property (@(posedge clk) reset |=> !ack)
    else $error("ack was high in the cycle after reset");

  // the requester drops req in the same cycle it sees ack, so look one edge back.
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

  ackHeldWhileReq: assert property (@(posedge clk) disable iff (reset)
    (ack && req) |=> ack)
    else $error("ack dropped while req was still high");

  responseStable: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> $stable(response))
    else $error("response changed while ack was high");

endmodule

bind addressGenerator addressGenerator_asserts u_asserts
(
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .response (response)
);

// File: sim/clockGen.sv
`timescale 1ns/100ps

module clockGen
(
  output logic clk,
  output logic reset
);

  // 4 ns period.
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset covers the first three rising edges and is released just after the third.
  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #0.5;
    reset = 1'b0;
  end

endmodule

// File: rtl/addressGenerator.sv
`timescale 1ns/100ps

module addressGenerator
(
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  input  dagPkg::dagRequestT  request,
  output logic                ack,
  output dagPkg::dagResponseT response
);

  logic             writeEnable;
  dagPkg::regKindT  writeKind;
  dagPkg::regSelT   writeSel;
  dagPkg::addrT     writeData;
  dagPkg::regSelT   indexSel;
  dagPkg::regSelT   modifySel;
  dagPkg::addrT     currentIndex;
  dagPkg::addrT     currentModifier;
  dagPkg::addrT     currentLength;
  dagPkg::addrT     newIndex;
  logic             wrapFlag;

  accessSequencer u_sequencer
  (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .request      (request),
    .ack          (ack),
    .response     (response),
    .writeEnable  (writeEnable),
    .writeKind    (writeKind),
    .writeSel     (writeSel),
    .writeData    (writeData),
    .indexSel     (indexSel),
    .modifySel    (modifySel),
    .currentIndex (currentIndex),
    .newIndex     (newIndex),
    .wrap         (wrapFlag)
  );

  dagRegisterFile u_registers
  (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (writeEnable),
    .writeKind   (writeKind),
    .writeSel    (writeSel),
    .writeData   (writeData),
    .indexSel    (indexSel),
    .modifySel   (modifySel),
    .index       (currentIndex),
    .modifier    (currentModifier),
    .length      (currentLength)
  );

  // combinational, so the new index is ready in the same cycle as the read.
  moduloUpdate u_modulo
  (
    .index    (currentIndex),
    .modifier (currentModifier),
    .length   (currentLength),
    .newIndex (newIndex),
    .wrap     (wrapFlag)
  );

endmodule

// File: rtl/accessSequencer.sv
`timescale 1ns/100ps

module accessSequencer
(
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  input  dagPkg::dagRequestT  request,
  output logic                ack,
  output dagPkg::dagResponseT response,
  output logic                writeEnable,
  output dagPkg::regKindT     writeKind,
  output dagPkg::regSelT      writeSel,
  output dagPkg::addrT        writeData,
  output dagPkg::regSelT      indexSel,
  output dagPkg::regSelT      modifySel,
  input  dagPkg::addrT        currentIndex,
  input  dagPkg::addrT        newIndex,
  input  logic                wrap
);

  dagPkg::seqStateT   state;
  dagPkg::dagRequestT held;
  logic               isAccess;

  // the request is captured once, on the edge that accepts it.
  always_ff @(posedge clk)
  begin
    if (state == dagPkg::stIdle && req)
    begin
      held <= request;
    end
  end

  assign isAccess = (held.op == dagPkg::opAccess);
  assign indexSel = held.indexSel;
  assign modifySel = held.modifySel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // only stExecute writes, so a held req never causes a second update.
  assign writeEnable = (state == dagPkg::stExecute);

  // an access post-modifies I; a write to M is addressed by modifySel, a
  // write to I or L by indexSel.
  always_comb
  begin
    if (isAccess)
    begin
      writeKind = dagPkg::kindIndex;
      writeSel = held.indexSel;
      writeData = newIndex;
    end
    else
    begin
      writeKind = held.kind;
      writeSel = (held.kind == dagPkg::kindModify) ? held.modifySel : held.indexSel;
      writeData = held.data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= dagPkg::stIdle;
      ack <= 1'b0;
      response <= '0;
    end
    else
    begin
      case (state)
        dagPkg::stIdle:
        begin
          if (req)
          begin
            state <= dagPkg::stExecute;
          end
        end
        dagPkg::stExecute:
        begin
          // the old index goes out, the register takes the new one.
          response.address <= isAccess ? currentIndex : held.data;
          response.wrap <= isAccess & wrap;
          state <= dagPkg::stAck;
        end
        dagPkg::stAck:
        begin
          ack <= 1'b1;
          state <= dagPkg::stRelease;
        end
        dagPkg::stRelease:
        begin
          if (!req)
          begin
            ack <= 1'b0;
            state <= dagPkg::stIdle;
          end
        end
        default:
        begin
          state <= dagPkg::stIdle;
        end
      endcase
    end
  end

endmodule

// File: rtl/dagRegisterFile.sv
`timescale 1ns/100ps

module dagRegisterFile
(
  input  logic             clk,
  input  logic             reset,
  input  logic             writeEnable,
  input  dagPkg::regKindT  writeKind,
  input  dagPkg::regSelT   writeSel,
  input  dagPkg::addrT     writeData,
  input  dagPkg::regSelT   indexSel,
  input  dagPkg::regSelT   modifySel,
  output dagPkg::addrT     index,
  output dagPkg::addrT     modifier,
  output dagPkg::addrT     length
);

  dagPkg::addrT indexRegs [dagPkg::numRegs];
  dagPkg::addrT modifyRegs [dagPkg::numRegs];
  dagPkg::addrT lengthRegs [dagPkg::numRegs];

  // one write per cycle into whichever bank writeKind names.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < dagPkg::numRegs; i++)
      begin
        indexRegs[i] <= '0;
        modifyRegs[i] <= '0;
        lengthRegs[i] <= '0;
      end
    end
    else if (writeEnable)
    begin
      case (writeKind)
        dagPkg::kindIndex:
        begin
          indexRegs[writeSel] <= writeData;
        end
        dagPkg::kindModify:
        begin
          modifyRegs[writeSel] <= writeData;
        end
        dagPkg::kindLength:
        begin
          lengthRegs[writeSel] <= writeData;
        end
        default:
        begin
        end
      endcase
    end
  end

  assign index = indexRegs[indexSel];
  assign modifier = modifyRegs[modifySel];

  // each length belongs to its index register, so it follows indexSel.
  assign length = lengthRegs[indexSel];

endmodule

// File: rtl/moduloUpdate.sv
`timescale 1ns/100ps

module moduloUpdate
(
  input  dagPkg::addrT index,
  input  dagPkg::addrT modifier,
  input  dagPkg::addrT length,
  output dagPkg::addrT newIndex,
  output logic         wrap
);

  dagPkg::addrT upperMask;
  dagPkg::addrT lowerMask;
  dagPkg::addrT baseMask;
  dagPkg::addrT offsetMask;
  dagPkg::addrT base;
  dagPkg::addrT offset;
  dagPkg::addrT result;
  logic         notPow2;
  logic         lengthNonZero;
  logic         modNeg;
  logic [14:0]  offsetExt;
  logic [14:0]  modifierExt;
  logic [14:0]  lengthExt;
  logic [14:0]  csaSum;
  logic [13:0]  csaCarry;
  logic [14:0]  sumAM;
  logic [14:0]  sumAML;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // length decode.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // upperMask fills from the highest set bit of L downwards, lowerMask
  // fills from the lowest set bit upwards.
  always_comb
  begin : maskDecode
    logic fillDown;
    logic fillUp;
    fillDown = 1'b0;
    fillUp = 1'b0;
    for (int i = dagPkg::addrWidth - 1; i >= 0; i--)
    begin
      fillDown = fillDown | length[i];
      upperMask[i] = fillDown;
    end
    for (int i = 0; i < dagPkg::addrWidth; i++)
    begin
      fillUp = fillUp | length[i];
      lowerMask[i] = fillUp;
    end
  end

  // more than one bit set in L.
  assign notPow2 = |(length & (length - 1'b1));
  assign lengthNonZero = |length;

  // for L = 0 both masks are zero, so the offset takes all 14 bits.
  assign baseMask = notPow2 ? ~upperMask : lowerMask;
  assign offsetMask = notPow2 ? upperMask : ~lowerMask;

  assign base = index & baseMask;
  assign offset = index & offsetMask;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // offset arithmetic.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign modNeg = modifier[dagPkg::addrWidth-1];
  assign offsetExt = {1'b0, offset};
  assign modifierExt = {modNeg, modifier};

  // a negative step may need L added back, a positive one L taken off.
  // -L is the inverted length plus the carry-in of the second adder.
  assign lengthExt = modNeg ? {1'b0, length} : {1'b1, ~length};

  lookaheadAdder u_sumAM
  (
    .a       (offsetExt),
    .b       (modifierExt),
    .carryIn (1'b0),
    .sum     (sumAM)
  );

  // three operands reduced to two before the second adder.
  assign csaSum = offsetExt ^ modifierExt ^ lengthExt;
  assign csaCarry = (offsetExt[13:0] & modifierExt[13:0])
                  | (offsetExt[13:0] & lengthExt[13:0])
                  | (modifierExt[13:0] & lengthExt[13:0]);

  lookaheadAdder u_sumAML
  (
    .a       (csaSum),
    .b       ({csaCarry, 1'b0}),
    .carryIn (~modNeg),
    .sum     (sumAML)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bit 14 of each sum is its sign. With L = 0 the corrected sum equals the
  // plain sum, so either choice gives the linear result.
  always_comb
  begin
    if (modNeg)
    begin
      result = sumAM[14] ? sumAML[13:0] : sumAM[13:0];
    end
    else
    begin
      result = sumAML[14] ? sumAM[13:0] : sumAML[13:0];
    end
  end

  assign newIndex = base | result;

  // the buffer end was crossed in the direction of the step.
  assign wrap = lengthNonZero & (modNeg ? sumAM[14] : ~sumAML[14]);

endmodule

// File: rtl/lookaheadAdder.sv
`timescale 1ns/100ps

module lookaheadAdder
(
  input  logic [14:0] a,
  input  logic [14:0] b,
  input  logic        carryIn,
  output logic [14:0] sum
);

  logic [14:0] gen;
  logic [14:0] prop;
  logic [14:0] half;
  logic        genStart;
  logic [6:0]  gen1;
  logic [6:1]  prop1;
  logic [2:0]  gen2;
  logic [2:1]  prop2;
  logic        gen3;
  logic [14:0] carry;

  // bit level terms. genStart folds the carry-in into bit zero.
  assign gen = a & b;
  assign prop = a | b;
  assign half = a ^ b;
  assign genStart = gen[0] | (prop[0] & carryIn);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // groups of two, four and eight bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign gen1[0] = gen[1] | (prop[1] & genStart);
  for (genvar j = 1; j < 7; j++)
  begin : pairLevel
    assign gen1[j] = gen[2*j+1] | (prop[2*j+1] & gen[2*j]);
    assign prop1[j] = prop[2*j+1] & prop[2*j];
  end

  assign gen2[0] = gen1[1] | (prop1[1] & gen1[0]);
  assign gen2[1] = gen1[3] | (prop1[3] & gen1[2]);
  assign gen2[2] = gen1[5] | (prop1[5] & gen1[4]);
  assign prop2[1] = prop1[3] & prop1[2];
  assign prop2[2] = prop1[5] & prop1[4];

  // carry out of bits 7..0.
  assign gen3 = gen2[1] | (prop2[1] & gen2[0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // carries into each bit, then the sum.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign carry[0] = carryIn;
  assign carry[1] = genStart;
  assign carry[2] = gen1[0];
  assign carry[3] = gen[2] | (prop[2] & gen1[0]);
  assign carry[4] = gen2[0];
  assign carry[5] = gen[4] | (prop[4] & gen2[0]);
  assign carry[6] = gen1[2] | (prop1[2] & gen2[0]);
  assign carry[7] = gen[6] | (prop[6] & carry[6]);
  assign carry[8] = gen3;
  assign carry[9] = gen[8] | (prop[8] & gen3);
  assign carry[10] = gen1[4] | (prop1[4] & gen3);
  assign carry[11] = gen[10] | (prop[10] & carry[10]);
  assign carry[12] = gen2[2] | (prop2[2] & gen3);
  assign carry[13] = gen[12] | (prop[12] & carry[12]);
  assign carry[14] = gen1[6] | (prop1[6] & carry[12]);

  assign sum = half ^ carry;

endmodule

// File: rtl/dagPkg.sv
package dagPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and counts.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int addrWidth = 14;
  localparam int numRegs = 4;

  // an index, a two's complement modifier or a buffer length.
  typedef logic [addrWidth-1:0] addrT;

  // picks one register out of a bank.
  typedef logic [$clog2(numRegs)-1:0] regSelT;

  typedef enum logic [1:0]
  {
    kindIndex,
    kindModify,
    kindLength
  } regKindT;

  typedef enum logic
  {
    opWrite,
    opAccess
  } dagOpT;

  typedef enum logic [1:0]
  {
    stIdle,
    stExecute,
    stAck,
    stRelease
  } seqStateT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request channel payloads.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // kind and data are only meaningful for a write.
  typedef struct packed
  {
    dagOpT   op;
    regKindT kind;
    regSelT  indexSel;
    regSelT  modifySel;
    addrT    data;
  } dagRequestT;

  typedef struct packed
  {
    addrT address;
    logic wrap;
  } dagResponseT;

endpackage
